// ==== include/soc_settings.svh ====
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// CPU side of the peripheral bus

// Byte address width
`define SOC_ADDR_W 32

// Data word width
`define SOC_DATA_W 16

// Monitor RAM

// Depth in words, indexed by address bits 8 to 1
`define SOC_RAM_WORDS 256

// Serial port

// Clock cycles per serial bit, at least 2
`define SOC_UART_CLKS_PER_BIT 8

`endif

// ==== source/soc_pkg.sv ====
`default_nettype none

`include "soc_settings.svh"

package soc_pkg;

  // Width of a RAM word index
  localparam int RAM_IDX_W = $clog2(`SOC_RAM_WORDS);

  typedef logic [`SOC_DATA_W-1:0] bus_word_t;

  // Address bits 31 to 28, any other value is unmapped
  typedef enum logic [3:0] {
    REGION_MONITOR = 4'd0,
    REGION_UART    = 4'd1,
    REGION_DISPLAY = 4'd2
  } soc_region_e;

  // Register view, register number is offset bits 3 to 1
  typedef struct packed {
    soc_region_e             region;
    logic [`SOC_ADDR_W-9:0]  unused;
    logic [3:0]              offset;
  } io_addr_t;

  // Word memory view of a byte address
  typedef struct packed {
    logic [`SOC_ADDR_W-RAM_IDX_W-2:0] upper;
    logic [RAM_IDX_W-1:0]             index;
    logic                             byte_sel;
  } mem_addr_t;

  typedef union packed {
    io_addr_t  io;
    mem_addr_t mem;
  } soc_addr_u;

  // Active low, bit 0 is segment a and bit 6 is segment g
  typedef logic [6:0] seg_t;

endpackage

`default_nettype wire

// ==== source/soc_dev_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Link from the address decoder to one register device
interface soc_dev_if;

  // Write strobe, already qualified by select
  logic                            wr;

  // Register number or word index within the device
  logic [soc_pkg::RAM_IDX_W-1:0]   offset;

  soc_pkg::bus_word_t              wdata;
  soc_pkg::bus_word_t              rdata;

  modport decoder (
    output wr,
    output offset,
    output wdata,
    input  rdata
  );

  // Device side never sees a select
  modport device (
    input  wr,
    input  offset,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

// ==== source/bus_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire soc_pkg::soc_addr_u  addr,
  input  wire soc_pkg::bus_word_t  wdata,
  input  wire logic                write,
  input  wire logic                write_protect,
  soc_dev_if.decoder               ram,
  soc_dev_if.decoder               ser,
  output logic                     disp_wr,
  output logic [2:0]               sel,
  output soc_pkg::bus_word_t       rdata
);

  logic sel_monitor;
  logic sel_uart;
  logic sel_display;

  // Chip selects from the top address nibble
  assign sel_monitor = (addr.io.region == soc_pkg::REGION_MONITOR);
  assign sel_uart    = (addr.io.region == soc_pkg::REGION_UART);
  assign sel_display = (addr.io.region == soc_pkg::REGION_DISPLAY);

  // Bit 0 monitor, bit 1 uart, bit 2 display
  assign sel = {sel_display, sel_uart, sel_monitor};

  // Monitor RAM strobe blocked by the board switch
  assign ram.wr     = write & sel_monitor & ~write_protect;
  assign ram.offset = addr.mem.index;
  assign ram.wdata  = wdata;

  // UART register number zero extended to the offset width
  assign ser.wr     = write & sel_uart;
  assign ser.offset = {{(soc_pkg::RAM_IDX_W-3){1'b0}}, addr.io.offset[3:1]};
  assign ser.wdata  = wdata;

  assign disp_wr = write & sel_display;

  // Return data merge
  // display and unmapped regions read as zero
  always_comb begin
    rdata = '0;
    if (sel_monitor) begin
      rdata = rdata | ram.rdata;
    end
    if (sel_uart) begin
      rdata = rdata | ser.rdata;
    end
  end

  // Regions never overlap
  a_sel_onehot: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(sel)
  ) else $error("bus_decoder: more than one chip select active");

endmodule

`default_nettype wire

// ==== source/monitor_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

// Word RAM holding the monitor program
module monitor_ram (
  input  wire logic  clk,
  soc_dev_if.device  port
);

  // Contents undefined until written
  soc_pkg::bus_word_t mem [0:`SOC_RAM_WORDS-1];

  always_ff @(posedge clk) begin
    if (port.wr) begin
      mem[port.offset] <= port.wdata;
    end
  end

  // Asynchronous read
  assign port.rdata = mem[port.offset];

endmodule

`default_nettype wire

// ==== source/uart.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

// 8N1 serial port with the data register at 0 and status at 1
module uart (
  input  wire logic  clk,
  input  wire logic  rst_n,
  soc_dev_if.device  port,
  input  wire logic  rx,
  output logic       tx
);

  localparam int CPB   = `SOC_UART_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CPB);

  localparam logic [soc_pkg::RAM_IDX_W-1:0] REG_DATA   = '0;
  localparam logic [soc_pkg::RAM_IDX_W-1:0] REG_STATUS = (soc_pkg::RAM_IDX_W)'(1);

  logic             tx_busy;
  logic [9:0]       tx_shift;
  logic [3:0]       tx_bit_cnt;
  logic [CNT_W-1:0] tx_clk_cnt;

  logic [1:0]       rx_sync;
  logic             rx_busy;
  logic [3:0]       rx_bit_cnt;
  logic [CNT_W-1:0] rx_clk_cnt;
  logic [7:0]       rx_shift;
  logic [7:0]       rx_data;
  logic             rx_valid;

  // Transmitter sends start bit, data LSB first and stop bit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_busy    <= 1'b0;
      tx_shift   <= '1;
      tx_bit_cnt <= '0;
      tx_clk_cnt <= '0;
    end else if (!tx_busy) begin
      if (port.wr && port.offset == REG_DATA) begin
        tx_busy    <= 1'b1;
        tx_shift   <= {1'b1, port.wdata[7:0], 1'b0};
        tx_bit_cnt <= '0;
        tx_clk_cnt <= '0;
      end
    end else if (tx_clk_cnt == CNT_W'(CPB - 1)) begin
      tx_clk_cnt <= '0;
      if (tx_bit_cnt == 4'd9) begin
        tx_busy <= 1'b0;
      end else begin
        tx_bit_cnt <= tx_bit_cnt + 4'd1;
        tx_shift   <= {1'b1, tx_shift[9:1]};
      end
    end else begin
      tx_clk_cnt <= tx_clk_cnt + 1'b1;
    end
  end

  // Shifted-in ones keep the line idle after the stop bit
  assign tx = tx_shift[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync <= 2'b11;
    end else begin
      rx_sync <= {rx_sync[0], rx};
    end
  end

  // Receiver samples each bit at its middle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_busy    <= 1'b0;
      rx_bit_cnt <= '0;
      rx_clk_cnt <= '0;
      rx_valid   <= 1'b0;
    end else begin
      if (port.wr && port.offset == REG_STATUS) begin
        rx_valid <= 1'b0;
      end
      if (!rx_busy) begin
        if (!rx_sync[1]) begin
          rx_busy    <= 1'b1;
          rx_bit_cnt <= '0;
          rx_clk_cnt <= CNT_W'(CPB / 2 - 1);
        end
      end else if (rx_clk_cnt != '0) begin
        rx_clk_cnt <= rx_clk_cnt - 1'b1;
      end else begin
        rx_clk_cnt <= CNT_W'(CPB - 1);
        rx_bit_cnt <= rx_bit_cnt + 4'd1;
        if (rx_bit_cnt == 4'd0) begin
          // Glitch rather than a real start bit
          if (rx_sync[1]) begin
            rx_busy <= 1'b0;
          end
        end else if (rx_bit_cnt == 4'd9) begin
          rx_busy <= 1'b0;
          if (rx_sync[1]) begin
            rx_valid <= 1'b1;
          end
        end
      end
    end
  end

  // Received byte shift and holding registers
  always_ff @(posedge clk) begin
    if (rx_busy && rx_clk_cnt == '0) begin
      if (rx_bit_cnt != 4'd0 && rx_bit_cnt != 4'd9) begin
        rx_shift <= {rx_sync[1], rx_shift[7:1]};
      end
      if (rx_bit_cnt == 4'd9 && rx_sync[1]) begin
        rx_data <= rx_shift;
      end
    end
  end

  always_comb begin
    port.rdata = '0;
    if (port.offset == REG_DATA) begin
      port.rdata = soc_pkg::bus_word_t'(rx_data);
    end else if (port.offset == REG_STATUS) begin
      port.rdata = soc_pkg::bus_word_t'({rx_valid, tx_busy});
    end
  end

  a_tx_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    !tx_busy |-> tx
  ) else $error("uart: tx line low while transmitter idle");

endmodule

`default_nettype wire

// ==== source/status_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module status_display (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                wr,
  input  wire soc_pkg::bus_word_t  wdata,
  input  wire logic [2:0]          sel,
  input  wire logic                write,
  output soc_pkg::seg_t            hex0,
  output soc_pkg::seg_t            hex1,
  output soc_pkg::seg_t            hex2,
  output soc_pkg::seg_t            hex3,
  output logic [7:0]               ledg
);

  soc_pkg::bus_word_t shown;
  logic [3:0]         written;

  // Active low, segment g in bit 6
  function automatic soc_pkg::seg_t hex_to_seg(input logic [3:0] nib);
    case (nib)
      4'h0:    return 7'h40;
      4'h1:    return 7'h79;
      4'h2:    return 7'h24;
      4'h3:    return 7'h30;
      4'h4:    return 7'h19;
      4'h5:    return 7'h12;
      4'h6:    return 7'h02;
      4'h7:    return 7'h78;
      4'h8:    return 7'h00;
      4'h9:    return 7'h10;
      4'ha:    return 7'h08;
      4'hb:    return 7'h03;
      4'hc:    return 7'h46;
      4'hd:    return 7'h21;
      4'he:    return 7'h06;
      default: return 7'h0e;
    endcase
  endfunction

  // Bit 3 records writes to unmapped space
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shown   <= '0;
      written <= '0;
    end else begin
      if (wr) begin
        shown <= wdata;
      end
      if (write) begin
        written <= written | {~|sel, sel};
      end
    end
  end

  assign hex0 = hex_to_seg(shown[3:0]);
  assign hex1 = hex_to_seg(shown[7:4]);
  assign hex2 = hex_to_seg(shown[11:8]);
  assign hex3 = hex_to_seg(shown[15:12]);

  assign ledg = {write, sel, written};

endmodule

`default_nettype wire

// ==== source/soc_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module soc_bus (
  input  wire logic                   clock_50,
  input  wire logic                   rst_n,
  input  wire logic [`SOC_ADDR_W-1:0] addr,
  input  wire logic [`SOC_DATA_W-1:0] wdata,
  input  wire logic                   write,
  input  wire logic                   write_protect,
  input  wire logic                   serial_rx,
  output logic [`SOC_DATA_W-1:0]      rdata,
  output logic                        serial_tx,
  output logic [6:0]                  hex0,
  output logic [6:0]                  hex1,
  output logic [6:0]                  hex2,
  output logic [6:0]                  hex3,
  output logic [7:0]                  ledg
);

  logic       disp_wr;
  logic [2:0] sel;

  soc_dev_if ram_if ();
  soc_dev_if ser_if ();

  // Chip select and return data merge
  bus_decoder u_decoder (
    .clk           (clock_50),
    .rst_n         (rst_n),
    .addr          (addr),
    .wdata         (wdata),
    .write         (write),
    .write_protect (write_protect),
    .ram           (ram_if.decoder),
    .ser           (ser_if.decoder),
    .disp_wr       (disp_wr),
    .sel           (sel),
    .rdata         (rdata)
  );

  monitor_ram u_monitor_ram (
    .clk  (clock_50),
    .port (ram_if.device)
  );

  uart u_uart (
    .clk   (clock_50),
    .rst_n (rst_n),
    .port  (ser_if.device),
    .rx    (serial_rx),
    .tx    (serial_tx)
  );

  // Seven segment digits and bus activity LEDs
  status_display u_status_display (
    .clk   (clock_50),
    .rst_n (rst_n),
    .wr    (disp_wr),
    .wdata (wdata),
    .sel   (sel),
    .write (write),
    .hex0  (hex0),
    .hex1  (hex1),
    .hex2  (hex2),
    .hex3  (hex3),
    .ledg  (ledg)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_soc_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module tb_soc_bus;

  typedef enum logic [1:0] {
    OP_WRITE,
    OP_READ,
    OP_POLL,
    OP_SEG
  } op_e;

  // Data holds the write word, the poll mask or the shown word
  // Exp holds the read word, the poll value, the ledg top nibble or all of ledg
  typedef struct packed {
    op_e                     op;
    logic [`SOC_ADDR_W-1:0]  addr;
    logic                    wp;
    soc_pkg::bus_word_t      data;
    soc_pkg::bus_word_t      exp;
  } row_t;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic [`SOC_ADDR_W-1:0] addr;
  logic [`SOC_DATA_W-1:0] wdata;
  logic                   write;
  logic                   write_protect;
  logic                   serial_rx;
  logic [`SOC_DATA_W-1:0] rdata;
  logic                   serial_tx;
  logic [6:0]             hex0;
  logic [6:0]             hex1;
  logic [6:0]             hex2;
  logic [6:0]             hex3;
  logic [7:0]             ledg;

  int   seed = 27136;
  row_t rows[$];
  logic table_ready = 1'b0;

  always #50 clk = ~clk;

  // Serial loopback
  assign serial_rx = serial_tx;

  soc_bus u_soc_bus (
    .clock_50      (clk),
    .rst_n         (rst_n),
    .addr          (addr),
    .wdata         (wdata),
    .write         (write),
    .write_protect (write_protect),
    .serial_rx     (serial_rx),
    .rdata         (rdata),
    .serial_tx     (serial_tx),
    .hex0          (hex0),
    .hex1          (hex1),
    .hex2          (hex2),
    .hex3          (hex3),
    .ledg          (ledg)
  );

  // Lit segments per hex digit with segment a in bit 0
  function automatic soc_pkg::seg_t seg_for(input logic [3:0] nib);
    string         lit;
    soc_pkg::seg_t seg;
    case (nib)
      4'h0: lit = "abcdef";
      4'h1: lit = "bc";
      4'h2: lit = "abdeg";
      4'h3: lit = "abcdg";
      4'h4: lit = "bcfg";
      4'h5: lit = "acdfg";
      4'h6: lit = "acdefg";
      4'h7: lit = "abc";
      4'h8: lit = "abcdefg";
      4'h9: lit = "abcdfg";
      4'ha: lit = "abcefg";
      4'hb: lit = "cdefg";
      4'hc: lit = "adef";
      4'hd: lit = "bcdeg";
      4'he: lit = "adefg";
      default: lit = "aefg";
    endcase
    seg = '1;
    for (int i = 0; i < lit.len(); i++) begin
      seg[lit[i] - "a"] = 1'b0;
    end
    return seg;
  endfunction

  function automatic soc_pkg::soc_addr_u ram_addr(input int idx);
    soc_pkg::soc_addr_u a;
    a = '0;
    a.mem.index = idx[soc_pkg::RAM_IDX_W-1:0];
    return a;
  endfunction

  function automatic soc_pkg::soc_addr_u reg_addr(input soc_pkg::soc_region_e region,
                                                  input int num);
    soc_pkg::soc_addr_u a;
    a = '0;
    a.io.region = region;
    a.io.offset = {num[2:0], 1'b0};
    return a;
  endfunction

  task automatic check_word(input soc_pkg::bus_word_t got, input soc_pkg::bus_word_t exp,
                            input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "word compare failed");
    end
  endtask

  task automatic check_seg(input soc_pkg::seg_t got, input soc_pkg::seg_t exp,
                           input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s: got %b, expected %b", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "segment compare failed");
    end
  endtask

  task automatic add_row(input op_e op, input soc_pkg::soc_addr_u a, input logic wp,
                         input soc_pkg::bus_word_t data, input soc_pkg::bus_word_t exp);
    row_t r;
    r.op   = op;
    r.addr = a;
    r.wp   = wp;
    r.data = data;
    r.exp  = exp;
    rows.push_back(r);
  endtask

  task automatic build_table();
    soc_pkg::bus_word_t w [4];
    soc_pkg::bus_word_t shown;
    soc_pkg::bus_word_t b;
    int                 idx [4];
    idx = '{0, 255, 17, 128};
    // Digits show 0 after reset and nothing has been written
    add_row(OP_SEG, reg_addr(soc_pkg::REGION_DISPLAY, 0), 1'b0, 16'h0000, 16'h0040);
    // RAM round trip including both ends of the array
    for (int k = 0; k < 4; k++) begin
      w[k] = soc_pkg::bus_word_t'($random(seed));
      add_row(OP_WRITE, ram_addr(idx[k]), 1'b0, w[k], 16'h0009);
    end
    for (int k = 0; k < 4; k++) begin
      add_row(OP_READ, ram_addr(idx[k]), 1'b0, 16'h0000, w[k]);
    end
    // Protected writes keep old contents
    add_row(OP_WRITE, ram_addr(0), 1'b1, ~w[0], 16'h0009);
    add_row(OP_WRITE, ram_addr(255), 1'b1, ~w[1], 16'h0009);
    add_row(OP_READ, ram_addr(0), 1'b1, 16'h0000, w[0]);
    add_row(OP_READ, ram_addr(255), 1'b0, 16'h0000, w[1]);
    // Monitor and display regions written so far
    shown = soc_pkg::bus_word_t'($random(seed));
    add_row(OP_WRITE, reg_addr(soc_pkg::REGION_DISPLAY, 0), 1'b0, shown, 16'h000c);
    add_row(OP_SEG, reg_addr(soc_pkg::REGION_DISPLAY, 0), 1'b0, shown, 16'h0045);
    add_row(OP_READ, reg_addr(soc_pkg::REGION_DISPLAY, 0), 1'b0, 16'h0000, 16'h0000);
    add_row(OP_READ, reg_addr(soc_pkg::soc_region_e'(4'd3), 0), 1'b0, 16'h0000, 16'h0000);
    add_row(OP_READ, reg_addr(soc_pkg::soc_region_e'(4'd15), 1), 1'b0, 16'h0000, 16'h0000);
    for (int k = 0; k < 3; k++) begin
      b = soc_pkg::bus_word_t'($random(seed)) & 16'h00ff;
      add_row(OP_WRITE, reg_addr(soc_pkg::REGION_UART, 0), 1'b0, b, 16'h000a);
      // Wait for tx idle and rx_valid set
      add_row(OP_POLL, reg_addr(soc_pkg::REGION_UART, 1), 1'b0, 16'h0003, 16'h0002);
      add_row(OP_READ, reg_addr(soc_pkg::REGION_UART, 0), 1'b0, 16'h0000, b);
      add_row(OP_WRITE, reg_addr(soc_pkg::REGION_UART, 1), 1'b0, 16'h0000, 16'h000a);
      add_row(OP_READ, reg_addr(soc_pkg::REGION_UART, 1), 1'b0, 16'h0000, 16'h0000);
    end
    // Unmapped write leaves the digits alone
    add_row(OP_WRITE, reg_addr(soc_pkg::soc_region_e'(4'd15), 0), 1'b0, 16'hdead, 16'h0008);
    add_row(OP_SEG, reg_addr(soc_pkg::REGION_DISPLAY, 0), 1'b0, shown, 16'h004f);
  endtask

  task automatic apply_row(input row_t r, input int n);
    @(negedge clk);
    addr          = r.addr;
    write_protect = r.wp;
    wdata         = r.data;
    case (r.op)
      OP_WRITE: begin
        write = 1'b1;
        #20;
        check_word(soc_pkg::bus_word_t'(ledg[7:4]), r.exp,
                   $sformatf("row %0d ledg bus activity", n));
        @(negedge clk);
        write = 1'b0;
      end
      OP_READ: begin
        #20;
        check_word(rdata, r.exp, $sformatf("row %0d read at %h", n, r.addr));
      end
      OP_POLL: begin
        #20;
        while ((rdata & r.data) !== r.exp) begin
          @(negedge clk);
          #20;
        end
      end
      default: begin
        #20;
        check_seg(hex0, seg_for(r.data[3:0]), $sformatf("row %0d hex0", n));
        check_seg(hex1, seg_for(r.data[7:4]), $sformatf("row %0d hex1", n));
        check_seg(hex2, seg_for(r.data[11:8]), $sformatf("row %0d hex2", n));
        check_seg(hex3, seg_for(r.data[15:12]), $sformatf("row %0d hex3", n));
        check_word(soc_pkg::bus_word_t'(ledg), r.exp,
                   $sformatf("row %0d ledg", n));
      end
    endcase
  endtask

  initial begin : main
    int i;
    addr          = '0;
    wdata         = '0;
    write         = 1'b0;
    write_protect = 1'b0;
    rst_n         = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #20;
    check_word(soc_pkg::bus_word_t'(serial_tx), 16'h0001, "serial_tx idle after reset");
    for (i = 0; i < rows.size(); i++) begin
      apply_row(rows[i], i);
    end
    $display("NO ERRORS");
    $finish;
  end

  // Budget covers every row plus three serial frames
  initial begin : watchdog
    int limit;
    wait (table_ready);
    limit = rows.size() * 4 + 3 * 10 * `SOC_UART_CLKS_PER_BIT + 100;
    repeat (limit) @(posedge clk);
    $display("Timeout: the bus tests did not finish within %0d clock cycles", limit);
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
source/soc_pkg.sv
source/soc_dev_if.sv
source/bus_decoder.sv
source/monitor_ram.sv
source/uart.sv
source/status_display.sv
source/soc_bus.sv
testbench/tb_soc_bus.sv

// ==== Bender.yml ====
package:
  name: soc_bus

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/soc_pkg.sv
      - source/soc_dev_if.sv
      - source/bus_decoder.sv
      - source/monitor_ram.sv
      - source/uart.sv
      - source/status_display.sv
      - source/soc_bus.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_soc_bus.sv
